// ==== list.f ====
+incdir+rtl
rtl/exec_pkg.sv
rtl/adder_flags_if.sv
rtl/cla_adder32.sv
rtl/barrel_shifter32.sv
rtl/mag_comparator32.sv
rtl/result_stage.sv
rtl/exec_unit.sv
tests/tb_exec_unit.sv

// ==== rtl/adder_flags_if.sv ====
// carry and aux_carry already hold borrows when the adder runs a subtract
`timescale 1ns/1ps
`include "exec_settings.svh"

interface adder_flags_if;

   // adder result
   exec_pkg::word_t sum;

   // CF, OF and AF as the result stage uses them
   logic carry;
   logic overflow;
   logic aux_carry;

   modport src (output sum, carry, overflow, aux_carry);

   modport dst (input sum, carry, overflow, aux_carry);

endinterface

// ==== rtl/barrel_shifter32.sv ====
// purely combinational; counts run 0 to 31 and right shifts are arithmetic only
`timescale 1ns/1ps
`include "exec_settings.svh"

module barrel_shifter32 (
   input  exec_pkg::word_t             a,
   input  logic [`EXEC_SHIFT_BITS-1:0] cnt,
   input  logic                        right,
   output exec_pkg::word_t             shifted,
   output logic                        last_out
);

   localparam int W = `EXEC_WIDTH;
   localparam int S = `EXEC_SHIFT_BITS;

   // one extra bit per chain catches the bit leaving the far edge
   logic [W:0] lft [S+1];
   logic [W:0] rgt [S+1];

   // guard bits start at zero, so count 0 leaves last_out low
   assign lft[0] = {1'b0, a};
   assign rgt[0] = {a, 1'b0};

   for (genvar i = 0; i < S; i++) begin : g_stage
      localparam int SH = 1 << i;

      // zero fill from the right
      assign lft[i+1] = cnt[i] ? {lft[i][W-SH:0], {SH{1'b0}}} : lft[i];

      // sign fill from the left
      assign rgt[i+1] = cnt[i] ? {{SH{rgt[i][W]}}, rgt[i][W:SH]} : rgt[i];
   end

   assign shifted  = right ? rgt[S][W:1] : lft[S][W-1:0];
   assign last_out = right ? rgt[S][0] : lft[S][W];

endmodule

// ==== rtl/cla_adder32.sv ====
// purely combinational; EXEC_WIDTH must be a multiple of EXEC_GROUP_BITS
`timescale 1ns/1ps
`include "exec_settings.svh"

module cla_adder32 (
   input  exec_pkg::word_t a,
   input  exec_pkg::word_t b,
   input  logic            sub,
   adder_flags_if.src      flags
);

   localparam int W  = `EXEC_WIDTH;
   localparam int GB = `EXEC_GROUP_BITS;
   localparam int NG = W / GB;

   exec_pkg::word_t b_eff;
   logic            cin;
   logic [W-1:0]    g;
   logic [W-1:0]    p;
   logic [NG-1:0]   gg;
   logic [NG-1:0]   gp;
   logic [NG:0]     gc;
   logic [W:0]      c;

   // subtract as a + ~b + 1
   assign b_eff = sub ? ~b : b;
   assign cin   = sub;

   assign g = a & b_eff;
   assign p = a ^ b_eff;

   always_comb begin
      logic t;
      logic run_c;
      logic run_p;
      // group generate and propagate
      for (int j = 0; j < NG; j++) begin
         t = 1'b0;
         for (int k = 0; k < GB; k++) begin
            t = g[j*GB+k] | (p[j*GB+k] & t);
         end
         gg[j] = t;
         gp[j] = &p[j*GB +: GB];
      end
      // lookahead carry into each group, expanded back to cin
      gc[0] = cin;
      for (int j = 0; j < NG; j++) begin
         run_c = gg[j];
         run_p = gp[j];
         for (int k = j - 1; k >= 0; k--) begin
            run_c = run_c | (run_p & gg[k]);
            run_p = run_p & gp[k];
         end
         gc[j+1] = run_c | (run_p & cin);
      end
      // bit carries inside each group start from the group carry
      c[0] = gc[0];
      for (int j = 0; j < NG; j++) begin
         for (int k = 0; k < GB - 1; k++) begin
            c[j*GB+k+1] = g[j*GB+k] | (p[j*GB+k] & c[j*GB+k]);
         end
         c[(j+1)*GB] = gc[j+1];
      end
   end

   assign flags.sum       = p ^ c[W-1:0];
   // carries turn into borrows on a subtract
   assign flags.carry     = c[W] ^ sub;
   assign flags.aux_carry = gc[1] ^ sub;
   assign flags.overflow  = c[W] ^ c[W-1];

   // lookahead network against a plain 33-bit add
   always_comb begin
      if (!sub) begin
         assert ({flags.carry, flags.sum} == ({1'b0, a} + {1'b0, b}))
            else $error("lookahead sum and carry differ from a + b");
      end
   end

endmodule

// ==== rtl/exec_pkg.sv ====
// codes 5 to 7 are reserved and give a zero result with every flag clear
`include "exec_settings.svh"

package exec_pkg;

   // one data word
   typedef logic [`EXEC_WIDTH-1:0] word_t;

   // operation codes as seen on the op port
   typedef enum logic [`EXEC_OP_BITS-1:0] {
      OP_ADD = 0,
      OP_SUB = 1,
      OP_SAL = 2,
      OP_SAR = 3,
      OP_CMP = 4
   } op_e;

endpackage

// ==== rtl/exec_settings.svh ====
// widths are fixed at 32-bit data and a 5-bit shift count; EXEC_WIDTH must divide by 8
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// data word width
`define EXEC_WIDTH 32

// shift count width, log2 of the word width
`define EXEC_SHIFT_BITS 5

// carry-lookahead group size
// AF is taken from the carry out of group 0
`define EXEC_GROUP_BITS 4

// operation code width
`define EXEC_OP_BITS 3

`endif

// ==== rtl/exec_unit.sv ====
// result and flags arrive one cycle after op_valid; there is no back-pressure
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_unit (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            op_valid,
   input  exec_pkg::op_e   op,
   input  exec_pkg::word_t a,
   input  exec_pkg::word_t b,
   output logic            res_valid,
   output exec_pkg::word_t result,
   output logic            cf,
   output logic            of,
   output logic            af,
   output logic            zf
);

   exec_pkg::word_t shifted;
   logic            last_out;
   logic            a_gt_b;
   logic            b_gt_a;
   logic            equal;

   adder_flags_if add_flags ();

   cla_adder32 i_adder (
      .a     (a),
      .b     (b),
      .sub   (op == exec_pkg::OP_SUB),
      .flags (add_flags.src)
   );

   // shift count is the low bits of b
   barrel_shifter32 i_shifter (
      .a        (a),
      .cnt      (b[`EXEC_SHIFT_BITS-1:0]),
      .right    (op == exec_pkg::OP_SAR),
      .shifted  (shifted),
      .last_out (last_out)
   );

   mag_comparator32 i_comparator (
      .a      (a),
      .b      (b),
      .a_gt_b (a_gt_b),
      .b_gt_a (b_gt_a),
      .equal  (equal)
   );

   result_stage i_result (
      .clk       (clk),
      .rst_n     (rst_n),
      .op_valid  (op_valid),
      .op        (op),
      .add_in    (add_flags.dst),
      .shifted   (shifted),
      .last_out  (last_out),
      .a_gt_b    (a_gt_b),
      .b_gt_a    (b_gt_a),
      .equal     (equal),
      .res_valid (res_valid),
      .result    (result),
      .cf        (cf),
      .of        (of),
      .af        (af),
      .zf        (zf)
   );

endmodule

// ==== rtl/mag_comparator32.sv ====
// purely combinational unsigned compare; EXEC_WIDTH must be a multiple of 8
`timescale 1ns/1ps
`include "exec_settings.svh"

module mag_comparator32 (
   input  exec_pkg::word_t a,
   input  exec_pkg::word_t b,
   output logic            a_gt_b,
   output logic            b_gt_a,
   output logic            equal
);

   localparam int W  = `EXEC_WIDTH;
   localparam int NB = W / 8;
   localparam int NN = W / 4;

   logic [NB-1:0] byte_gt;
   logic [NB-1:0] byte_lt;
   logic [NB-1:0] byte_eq;
   logic [NN-1:0] nib_eq;

   for (genvar i = 0; i < NB; i++) begin : g_byte
      assign byte_gt[i] = a[i*8 +: 8] > b[i*8 +: 8];
      assign byte_lt[i] = a[i*8 +: 8] < b[i*8 +: 8];
      // byte equality from its two nibbles
      assign byte_eq[i] = nib_eq[2*i+1] & nib_eq[2*i];
   end

   for (genvar j = 0; j < NN; j++) begin : g_nibble
      assign nib_eq[j] = a[j*4 +: 4] == b[j*4 +: 4];
   end

   // a byte decides only while every byte above it matched
   always_comb begin
      logic hi_eq;
      hi_eq  = 1'b1;
      a_gt_b = 1'b0;
      b_gt_a = 1'b0;
      for (int i = NB - 1; i >= 0; i--) begin
         a_gt_b = a_gt_b | (hi_eq & byte_gt[i]);
         b_gt_a = b_gt_a | (hi_eq & byte_lt[i]);
         hi_eq  = hi_eq & byte_eq[i];
      end
      equal = hi_eq;
   end

   always_comb begin
      assert ($onehot({a_gt_b, b_gt_a, equal}))
         else $error("comparator outputs not one-hot");
   end

endmodule

// ==== rtl/result_stage.sv ====
// one-cycle register stage with no stall; result and flags hold while op_valid is low
`timescale 1ns/1ps
`include "exec_settings.svh"

module result_stage (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            op_valid,
   input  exec_pkg::op_e   op,
   adder_flags_if.dst      add_in,
   input  exec_pkg::word_t shifted,
   input  logic            last_out,
   input  logic            a_gt_b,
   input  logic            b_gt_a,
   input  logic            equal,
   output logic            res_valid,
   output exec_pkg::word_t result,
   output logic            cf,
   output logic            of,
   output logic            af,
   output logic            zf
);

   exec_pkg::word_t res_d;
   logic            cf_d;
   logic            of_d;
   logic            af_d;
   logic            op_known;

   always_comb begin
      res_d    = '0;
      cf_d     = 1'b0;
      of_d     = 1'b0;
      af_d     = 1'b0;
      op_known = 1'b1;
      case (op)
         exec_pkg::OP_ADD, exec_pkg::OP_SUB: begin
            res_d = add_in.sum;
            cf_d  = add_in.carry;
            of_d  = add_in.overflow;
            af_d  = add_in.aux_carry;
         end
         exec_pkg::OP_SAL, exec_pkg::OP_SAR: begin
            res_d = shifted;
            cf_d  = last_out;
         end
         exec_pkg::OP_CMP: begin
            res_d = {{(`EXEC_WIDTH-3){1'b0}}, equal, b_gt_a, a_gt_b};
         end
         // reserved codes leave ZF clear as well
         default: op_known = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
         result    <= '0;
         cf        <= 1'b0;
         of        <= 1'b0;
         af        <= 1'b0;
         zf        <= 1'b0;
      end else begin
         res_valid <= op_valid;
         if (op_valid) begin
            result <= res_d;
            cf     <= cf_d;
            of     <= of_d;
            af     <= af_d;
            zf     <= op_known & (res_d == '0);
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) res_valid |-> !$isunknown(result))
      else $error("result unknown while res_valid is high");

   // shifts and compare never report signed overflow
   assert property (@(posedge clk) disable iff (!rst_n)
      op_valid && (op == exec_pkg::OP_SAL || op == exec_pkg::OP_SAR ||
                   op == exec_pkg::OP_CMP) |=> !of)
      else $error("OF set after a shift or compare");

endmodule

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and judge the log
set -e

verilator --binary -f list.f --top-module tb_exec_unit -o sim_exec_unit
./obj_dir/sim_exec_unit > sim.log 2>&1
cat sim.log

if grep -q "All tests passed!" sim.log; then
   exit 0
else
   exit 1
fi

// ==== tests/tb_exec_unit.sv ====
// inputs change on the falling edge, outputs are checked at the next one; stops at 2000 cycles
`timescale 1ns/1ps
`include "exec_settings.svh"

module tb_exec_unit;

   // about twice the cycles the six tests take
   localparam int TIMEOUT_CYCLES = 2000;

   logic                   clk;
   logic                   rst_n;
   logic                   op_valid;
   exec_pkg::op_e          op;
   logic [`EXEC_WIDTH-1:0] a;
   logic [`EXEC_WIDTH-1:0] b;
   logic                   res_valid;
   logic [`EXEC_WIDTH-1:0] result;
   logic                   cf;
   logic                   of;
   logic                   af;
   logic                   zf;

   // model of the registered outputs
   logic                   m_valid;
   logic [`EXEC_WIDTH-1:0] m_result;
   logic                   m_cf;
   logic                   m_of;
   logic                   m_af;
   logic                   m_zf;

   logic [15:0] lfsr_state;
   int          errors;
   int          checks;
   int          tests;
   int          cycles;
   int          err_start;

   exec_unit i_exec_unit (
      .clk       (clk),
      .rst_n     (rst_n),
      .op_valid  (op_valid),
      .op        (op),
      .a         (a),
      .b         (b),
      .res_valid (res_valid),
      .result    (result),
      .cf        (cf),
      .of        (of),
      .af        (af),
      .zf        (zf)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("simulation timed out after %0d cycles", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic report_field(input string name, input logic [31:0] got, input logic [31:0] exp);
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
   endtask

   task automatic check_outputs();
      checks++;
      if (res_valid !== m_valid) report_field("res_valid", 32'(res_valid), 32'(m_valid));
      if (result !== m_result) report_field("result", result, m_result);
      if (cf !== m_cf) report_field("cf", 32'(cf), 32'(m_cf));
      if (of !== m_of) report_field("of", 32'(of), 32'(m_of));
      if (af !== m_af) report_field("af", 32'(af), 32'(m_af));
      if (zf !== m_zf) report_field("zf", 32'(zf), 32'(m_zf));
   endtask

   // expected result and flags, worked out in 64-bit arithmetic
   task automatic model_op(input exec_pkg::op_e o, input logic [31:0] x, input logic [31:0] y);
      logic [63:0] wide;
      logic [4:0]  nib;
      logic        known;
      m_result = '0;
      m_cf     = 1'b0;
      m_of     = 1'b0;
      m_af     = 1'b0;
      known    = 1'b1;
      case (o)
         exec_pkg::OP_ADD: begin
            wide     = {32'b0, x} + {32'b0, y};
            nib      = {1'b0, x[3:0]} + {1'b0, y[3:0]};
            m_result = wide[31:0];
            m_cf     = wide[32];
            m_af     = nib[4];
            m_of     = (x[31] == y[31]) && (wide[31] != x[31]);
         end
         exec_pkg::OP_SUB: begin
            wide     = {32'b0, x} - {32'b0, y};
            m_result = wide[31:0];
            m_cf     = x < y;
            m_af     = x[3:0] < y[3:0];
            m_of     = (x[31] != y[31]) && (wide[31] != x[31]);
         end
         // guard bits start at zero, so count 0 gives CF 0
         exec_pkg::OP_SAL: begin
            wide     = {32'b0, x} << y[4:0];
            m_result = wide[31:0];
            m_cf     = wide[32];
         end
         exec_pkg::OP_SAR: begin
            wide     = $signed({x, 32'b0}) >>> y[4:0];
            m_result = wide[63:32];
            m_cf     = wide[31];
         end
         exec_pkg::OP_CMP: m_result = (x > y) ? 32'd1 : ((y > x) ? 32'd2 : 32'd4);
         default: known = 1'b0;
      endcase
      m_zf = known && (m_result == '0);
   endtask

   // check the last cycle, then drive the next one
   task automatic step(input logic v, input exec_pkg::op_e o, input logic [31:0] x,
                       input logic [31:0] y);
      @(negedge clk);
      check_outputs();
      if (v) model_op(o, x, y);
      m_valid  = v;
      op_valid = v;
      op       = o;
      a        = x;
      b        = y;
   endtask

   task automatic run_op_test(input exec_pkg::op_e kind, input int count);
      logic [31:0]   x;
      logic [31:0]   y;
      exec_pkg::op_e o;
      for (int i = 0; i < count; i++) begin
         x = take_bits(32);
         y = take_bits(32);
         o = kind;
         if (kind == exec_pkg::OP_ADD) begin
            // carry out of bit 31, positive overflow, nibble carry
            if (i % 8 == 0) begin
               x[31] = 1'b1;
               y[31] = 1'b1;
            end
            if (i % 8 == 1) begin
               x[31:30] = 2'b01;
               y[31:30] = 2'b01;
            end
            if (i % 8 == 2) begin
               x[3:0] = 4'hf;
               y[0]   = 1'b1;
            end
         end else if (kind == exec_pkg::OP_SUB) begin
            if (i % 8 == 0) y = x;
            if (i % 8 == 1) begin
               y[31] = 1'b1;
               x = y >> 1;
            end
         end else if (kind == exec_pkg::OP_CMP) begin
            if (i % 8 == 0) y = x;
         end else begin
            o = (take_bits(1) != 0) ? exec_pkg::OP_SAR : exec_pkg::OP_SAL;
            if (i % 8 == 0) y[4:0] = 5'd0;
            if (i % 8 == 1) begin
               y[4:0] = 5'd31;
               x[31]  = 1'b1;
            end
         end
         step(1'b1, o, x, y);
      end
      step(1'b0, kind, '0, '0);
   endtask

   task automatic run_mixed_test(input int count);
      logic [31:0] sel;
      logic        v;
      for (int i = 0; i < count; i++) begin
         sel = take_bits(5);
         v   = sel[4:3] != 2'b00;
         step(v, exec_pkg::op_e'(sel[2:0]), take_bits(32), take_bits(32));
      end
      step(1'b0, exec_pkg::OP_ADD, '0, '0);
      // res_valid must drop after the last operation
      @(negedge clk);
      check_outputs();
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("%s: %0d errors", name, errors - err_start);
      err_start = errors;
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      op_valid   = 1'b0;
      op         = exec_pkg::OP_ADD;
      a          = '0;
      b          = '0;
      lfsr_state = 16'd24780;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      err_start  = 0;
      {m_valid, m_result, m_cf, m_of, m_af, m_zf} = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // reset state, one ADD, then res_valid must drop again
      step(1'b0, exec_pkg::OP_ADD, '0, '0);
      step(1'b1, exec_pkg::OP_ADD, 32'h8000_000f, 32'h8000_0001);
      step(1'b0, exec_pkg::OP_ADD, '0, '0);
      step(1'b0, exec_pkg::OP_ADD, '0, '0);
      finish_test("reset and single op");

      run_op_test(exec_pkg::OP_ADD, 200);
      finish_test("add");
      run_op_test(exec_pkg::OP_SUB, 200);
      finish_test("sub");
      run_op_test(exec_pkg::OP_SAL, 200);
      finish_test("sal and sar");
      run_op_test(exec_pkg::OP_CMP, 200);
      finish_test("cmp");
      run_mixed_test(300);
      finish_test("mixed stream");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
